/* all.f */
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu.sv
verilog/op_queue.sv
verilog/alu_csr.sv
verilog/result_stage.sv
verilog/alu_exec_top.sv
tb/alu_exec_properties.sv
tb/alu_exec_tb.sv

/* tb/alu_exec_tb.sv */
// ALU execute unit testbench: credit driver, reference model, scoreboard, tests
`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_exec_tb;
  import alu_pkg::*;

  localparam int       TIMEOUT = 2000;           // Cycles allowed per wait
  localparam op_mask_t IMPL    = `ALU_OP_IMPL;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  alu_op_t     in_op;
  word_t       in_a;
  word_t       in_b;
  logic        in_credit;
  logic        out_valid;
  word_t       out_result;
  logic        out_zero;
  logic        out_negative;
  logic        out_borrow;
  logic        out_illegal;
  logic        out_credit;
  logic        csr_we;
  logic [1:0]  csr_addr;
  word_t       csr_wdata;
  word_t       csr_rdata;

  int          seed;
  int          sent;                             // Pushes issued
  int          returned;                         // in_credit pulses seen
  int          rx_count;                         // Results received
  int          ill_rx;                           // Illegal results received
  int          owed;                             // out_credit pulses still due
  logic        hold_credits;                     // Withhold out_credit
  int          err_count;
  int          check_count;
  int          tests_run;
  logic        timed_out;
  op_mask_t    mask_shadow;                      // Mask the DUT should hold
  logic [40:0] exp_q [$];                        // {op, ill, borrow, neg, zero, result}

  alu_exec_top i_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Expected result and flags, packed as {ill, borrow, neg, zero, result}
  function automatic logic [35:0] ref_alu(input alu_op_t op, input word_t a, input word_t b,
                                          input op_mask_t mask);
    word_t r;
    logic  bo;
    logic  ill;
    r   = '0;
    bo  = 1'b0;
    ill = !mask[op];
    case (op)
      OP_AND:        r = a & b;
      OP_OR:         r = a | b;
      OP_ADD:        r = a + b;
      OP_XOR:        r = a ^ b;
      OP_SUB:        r = a - b;
      OP_NOT:        r = ~a;
      OP_SLL:        r = (b > 31) ? '0 : (a << b[4:0]);
      OP_SRL:        r = (b > 31) ? '0 : (a >> b[4:0]);
      OP_SRA:
      begin
        if (b > 31)
          r = {32{a[31]}};                       // Everything shifted out, sign left
        else
          r = $signed(a) >>> b[4:0];
      end
      OP_SLT:        r = {31'b0, $signed(a) < $signed(b)};
      OP_SLTU:       r = {31'b0, a < b};
      OP_AMOMIN:     r = ($signed(a) < $signed(b)) ? a : b;
      OP_AMOMAX:     r = ($signed(a) < $signed(b)) ? b : a;
      OP_AMOMINU:    r = (a < b) ? a : b;
      OP_AMOMAXU:    r = (a < b) ? b : a;
      OP_SUB_BORROW:
      begin
        r  = a - b;
        bo = (b > a);                            // Borrow when b is larger
      end
      default:       r = '0;
    endcase
    if (ill)
    begin
      r  = '0;
      bo = 1'b0;
    end
    return {ill, bo, r[31], (r == '0), r};
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    check_count++;
    if (got !== expected)
    begin
      $display("** Error at %0t ns: %s got %0h expected %0h", $time, what, got, expected);
      err_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    timed_out = 1'b1;
  endtask

  task automatic finish_test(input string name, input int errs0);
    tests_run++;
    $display("Test %-8s finished with %0d errors", name, err_count - errs0);
  endtask

  task automatic rand_operand(output word_t v);
    logic [31:0] r;
    r = $random(seed);
    case (r[2:0])
      3'd0:    v = 32'h0000_0000;
      3'd1:    v = 32'hFFFF_FFFF;
      3'd2:    v = 32'h8000_0000;                // Most negative
      3'd3:    v = $random(seed) & 32'h3F;       // Shift amounts up to 63
      default: v = $random(seed);
    endcase
  endtask

  // Waits for a free input credit, then pushes one operation
  task automatic send_op(input alu_op_t op, input word_t a, input word_t b);
    int n;
    n = 0;
    @(posedge clk);
    in_valid <= 1'b0;
    while ((sent - returned >= `ALU_QUEUE_DEPTH) && n < TIMEOUT)
    begin
      @(posedge clk);
      n++;
    end
    if (sent - returned >= `ALU_QUEUE_DEPTH)
      report_timeout("input credit return");
    else
    begin
      in_valid <= 1'b1;
      in_op    <= op;
      in_a     <= a;
      in_b     <= b;
      sent++;
      exp_q.push_back({op, ref_alu(op, a, b, mask_shadow)});
    end
  endtask

  function automatic bit drained();
    return (rx_count == sent) && (returned == sent) && (owed == 0) && !out_credit;
  endfunction

  task automatic wait_drained();
    int n;
    n = 0;
    while (!drained() && n < TIMEOUT)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
      n++;
    end
    if (!drained())
      report_timeout("queue drain");
  endtask

  task automatic wait_rx(input int target);
    int n;
    n = 0;
    while (rx_count < target && n < TIMEOUT)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
      n++;
    end
    if (rx_count < target)
      report_timeout("result delivery");
  endtask

  task automatic csr_write(input logic [1:0] addr, input word_t data);
    @(posedge clk);
    csr_we    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
    @(posedge clk);
    csr_we    <= 1'b0;
  endtask

  task automatic csr_read(input logic [1:0] addr, output word_t data);
    @(posedge clk);
    csr_we   <= 1'b0;
    csr_addr <= addr;
    @(posedge clk);
    data = csr_rdata;                            // Settled since last edge
  endtask

  // Scoreboard, credit bookkeeping and out_credit return
  always @(posedge clk)
  begin : monitor
    logic [40:0] expd;
    logic        give;
    if (out_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Result arrived at %0t ns with no operation outstanding", $time);
        err_count++;
      end
      else
      begin
        expd = exp_q.pop_front();
        check_value($sformatf("op %0d result", expd[40:36]), out_result, expd[31:0]);
        check_value($sformatf("op %0d flags ill/borrow/neg/zero", expd[40:36]),
                    {out_illegal, out_borrow, out_negative, out_zero}, expd[35:32]);
        if (expd[35])
          ill_rx <= ill_rx + 1;
      end
      rx_count <= rx_count + 1;
    end
    if (in_credit)
      returned <= returned + 1;
    give = !hold_credits && (owed != 0 || out_valid);
    out_credit <= give;
    owed       <= owed + int'(out_valid) - int'(give);
  end

  task automatic test_reset();
    int    errs0;
    int    i;
    word_t v;
    errs0 = err_count;
    for (i = 0; i < 8; i++)
    begin
      @(posedge clk);
      check_value("out_valid after reset", out_valid, 0);
      check_value("in_credit after reset", in_credit, 0);
    end
    csr_read(`ALU_CSR_MASK, v);
    check_value("mask after reset", v, `ALU_OP_IMPL);
    csr_read(`ALU_CSR_DONE_CNT, v);
    check_value("done count after reset", v, 0);
    csr_read(`ALU_CSR_ILL_CNT, v);
    check_value("illegal count after reset", v, 0);
    finish_test("reset", errs0);
  endtask

  // Runs n random pairs through every opcode selected by sel
  task automatic run_ops(input op_mask_t sel, input int n);
    int    k;
    int    i;
    word_t a;
    word_t b;
    for (k = 0; k < 32; k++)
    begin
      if (sel[k])
      begin
        for (i = 0; i < n && !timed_out; i++)
        begin
          rand_operand(a);
          rand_operand(b);
          send_op(alu_op_t'(k), a, b);
        end
      end
    end
    wait_drained();
  endtask

  task automatic test_burst();
    int    errs0;
    int    base;
    int    i;
    word_t a;
    word_t b;
    errs0 = err_count;
    base  = rx_count;
    @(posedge clk);
    hold_credits <= 1'b1;                        // Receiver stalls
    for (i = 0; i < `ALU_QUEUE_DEPTH; i++)
    begin
      rand_operand(a);
      rand_operand(b);
      send_op(OP_SUB, a, b);
    end
    wait_rx(base + `ALU_OUT_CREDITS);
    for (i = 0; i < 12; i++)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
    check_value("results while stalled", rx_count - base, `ALU_OUT_CREDITS);
    check_value("input credits while stalled", sent - returned,
                `ALU_QUEUE_DEPTH - `ALU_OUT_CREDITS);
    @(posedge clk);
    hold_credits <= 1'b0;
    wait_drained();
    check_value("results after release", rx_count - base, `ALU_QUEUE_DEPTH);
    check_value("input credits restored", sent - returned, 0);
    finish_test("burst", errs0);
  endtask

  task automatic test_mask();
    int       errs0;
    word_t    v;
    op_mask_t m;
    errs0 = err_count;
    m = IMPL & ~((op_mask_t'(1) << OP_ADD) | (op_mask_t'(1) << OP_AMOMIN) |
                 (op_mask_t'(1) << OP_AMOMINU));
    csr_write(`ALU_CSR_MASK, m);
    mask_shadow = m;
    csr_read(`ALU_CSR_MASK, v);
    check_value("mask readback", v, m);
    run_ops(IMPL, 10);                           // add and min now illegal
    csr_write(`ALU_CSR_MASK, 32'hFFFF_FFFF);
    mask_shadow = IMPL;
    csr_read(`ALU_CSR_MASK, v);
    check_value("mask readback all ones", v, `ALU_OP_IMPL);
    run_ops(op_mask_t'(1) << OP_ADD, 10);
    finish_test("mask", errs0);
  endtask

  task automatic test_counters();
    int    errs0;
    word_t v;
    errs0 = err_count;
    csr_read(`ALU_CSR_DONE_CNT, v);
    check_value("done count", v, rx_count);
    csr_read(`ALU_CSR_ILL_CNT, v);
    check_value("illegal count", v, ill_rx);
    finish_test("counters", errs0);
  endtask

  initial
  begin
    int errs0;
    seed         = 32'h146d4e74;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_op        = '0;
    in_a         = '0;
    in_b         = '0;
    out_credit   = 1'b0;
    csr_we       = 1'b0;
    csr_addr     = '0;
    csr_wdata    = '0;
    sent         = 0;
    returned     = 0;
    rx_count     = 0;
    ill_rx       = 0;
    owed         = 0;
    hold_credits = 1'b0;
    err_count    = 0;
    check_count  = 0;
    tests_run    = 0;
    timed_out    = 1'b0;
    mask_shadow  = IMPL;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    test_reset();
    if (!timed_out)
    begin
      errs0 = err_count;
      run_ops(IMPL, 200);
      finish_test("random", errs0);
    end
    if (!timed_out)
      test_burst();
    if (!timed_out)
    begin
      errs0 = err_count;
      run_ops(~IMPL, 4);                         // mul/div/rem and 24..31
      finish_test("illegal", errs0);
    end
    if (!timed_out)
      test_mask();
    if (!timed_out)
      test_counters();

    $display("Tests %0d, checks %0d, results %0d, errors %0d, assertions %0d, timeout %0d",
             tests_run, check_count, rx_count, err_count, i_dut.i_props.fail_count,
             timed_out);
    if (err_count == 0 && i_dut.i_props.fail_count == 0 && !timed_out)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* tb/alu_exec_properties.sv */
// ALU execute unit assertions: credit, valid and illegal result rules
`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_exec_properties (
  input logic                                     clk,
  input logic                                     rst_n,
  input logic                                     out_valid,
  input logic                                     in_credit,
  input logic                                     out_illegal,
  input alu_pkg::word_t                           out_result,
  input logic [$clog2(`ALU_OUT_CREDITS + 1)-1:0]  credit_cnt,
  input logic [$clog2(`ALU_QUEUE_DEPTH + 1)-1:0]  queue_count
);

  int fail_count = 0;                            // Assertion failures so far

  // Issue spends a credit, so one must have been there the cycle before
  issue_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(credit_cnt) != '0)
    else
    begin
      $error("out_valid raised with no output credit");
      fail_count++;
    end

  credit_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
    in_credit == out_valid)                      // Freed slot per result
    else
    begin
      $error("in_credit and out_valid differ");
      fail_count++;
    end

  queue_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    queue_count <= `ALU_QUEUE_DEPTH)
    else
    begin
      $error("queue count above depth");
      fail_count++;
    end

  illegal_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && out_illegal) |-> out_result == '0)
    else
    begin
      $error("illegal result is not zero");
      fail_count++;
    end

endmodule

bind alu_exec_top alu_exec_properties i_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .out_valid   (out_valid),
  .in_credit   (in_credit),
  .out_illegal (out_illegal),
  .out_result  (out_result),
  .credit_cnt  (i_result_stage.credit_cnt),
  .queue_count (i_op_queue.count)
);

/* verilog/alu_exec_top.sv */
// ALU execute unit top: queue, ALU, result stage and register block
`timescale 1ns/1ps

module alu_exec_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  alu_pkg::alu_op_t in_op,
  input  alu_pkg::word_t   in_a,
  input  alu_pkg::word_t   in_b,
  output logic             in_credit,
  output logic             out_valid,
  output alu_pkg::word_t   out_result,
  output logic             out_zero,
  output logic             out_negative,
  output logic             out_borrow,
  output logic             out_illegal,
  input  logic             out_credit,
  input  logic             csr_we,
  input  logic [1:0]       csr_addr,
  input  alu_pkg::word_t   csr_wdata,
  output alu_pkg::word_t   csr_rdata
);
  import alu_pkg::*;

  logic     head_valid; // Queue head
  alu_op_t  head_op;
  word_t    head_a;
  word_t    head_b;
  logic     pop;
  word_t    alu_result; // Combinational ALU out
  logic     alu_zero;
  logic     alu_negative;
  logic     alu_borrow;
  op_mask_t op_mask;
  logic     done;       // Result stage event pulses
  logic     illegal;

  op_queue i_op_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (in_valid),
    .push_op    (in_op),
    .push_a     (in_a),
    .push_b     (in_b),
    .pop        (pop),
    .head_valid (head_valid),
    .head_op    (head_op),
    .head_a     (head_a),
    .head_b     (head_b)
  );

  alu i_alu (
    .op       (head_op),
    .a        (head_a),
    .b        (head_b),
    .result   (alu_result),
    .zero     (alu_zero),
    .negative (alu_negative),
    .borrow   (alu_borrow)
  );

  result_stage i_result_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .head_valid   (head_valid),
    .head_op      (head_op),
    .alu_result   (alu_result),
    .alu_zero     (alu_zero),
    .alu_negative (alu_negative),
    .alu_borrow   (alu_borrow),
    .op_mask      (op_mask),
    .out_credit   (out_credit),
    .pop          (pop),
    .in_credit    (in_credit),
    .out_valid    (out_valid),
    .out_result   (out_result),
    .out_zero     (out_zero),
    .out_negative (out_negative),
    .out_borrow   (out_borrow),
    .out_illegal  (out_illegal),
    .done         (done),
    .illegal      (illegal)
  );

  alu_csr i_alu_csr (
    .clk       (clk),
    .rst_n     (rst_n),
    .csr_we    (csr_we),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .csr_rdata (csr_rdata),
    .done      (done),
    .illegal   (illegal),
    .op_mask   (op_mask)
  );

endmodule

/* verilog/result_stage.sv */
// Result stage: output credits, issue, illegal check and result register
`timescale 1ns/1ps

`include "alu_defines.svh"

module result_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              head_valid,
  input  alu_pkg::alu_op_t  head_op,
  input  alu_pkg::word_t    alu_result,
  input  logic              alu_zero,
  input  logic              alu_negative,
  input  logic              alu_borrow,
  input  alu_pkg::op_mask_t op_mask,
  input  logic              out_credit,
  output logic              pop,
  output logic              in_credit,
  output logic              out_valid,
  output alu_pkg::word_t    out_result,
  output logic              out_zero,
  output logic              out_negative,
  output logic              out_borrow,
  output logic              out_illegal,
  output logic              done,
  output logic              illegal
);
  localparam int CW = $clog2(`ALU_OUT_CREDITS + 1);

  logic [CW-1:0] credit_cnt; // Receiver credits left
  logic          head_ill;   // Head opcode disabled or unimplemented

  assign pop      = head_valid && (credit_cnt != '0);
  assign head_ill = !op_mask[head_op];

  // Count follows pop and the returned pulses
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      credit_cnt  <= CW'(`ALU_OUT_CREDITS);
      out_valid   <= 1'b0;
      in_credit   <= 1'b0;
      out_illegal <= 1'b0;
    end
    else
    begin
      credit_cnt <= credit_cnt - CW'(pop) + CW'(out_credit);
      out_valid  <= pop;                      // One cycle per issue
      in_credit  <= pop;                      // Freed slot back to sender
      if (pop)
        out_illegal <= head_ill;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      out_result   <= head_ill ? '0 : alu_result; // Illegal reads as zero
      out_zero     <= head_ill | alu_zero;
      out_negative <= !head_ill && alu_negative;
      out_borrow   <= !head_ill && alu_borrow;
    end
  end

  assign done    = out_valid;                 // Counted the edge after
  assign illegal = out_valid && out_illegal;

endmodule

/* verilog/alu_csr.sv */
// ALU register block: opcode enable mask, done and illegal counters
`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_csr (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              csr_we,
  input  logic [1:0]        csr_addr,
  input  alu_pkg::word_t    csr_wdata,
  output alu_pkg::word_t    csr_rdata,
  input  logic              done,
  input  logic              illegal,
  output alu_pkg::op_mask_t op_mask
);
  import alu_pkg::*;

  cnt_t done_cnt; // Completed ops, wraps
  cnt_t ill_cnt;  // Illegal ops, wraps

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      op_mask <= `ALU_OP_IMPL;                  // All implemented ops on
    else if (csr_we && (csr_addr == `ALU_CSR_MASK))
      op_mask <= csr_wdata & `ALU_OP_IMPL;      // Unimplemented bits stay 0
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      done_cnt <= '0;
      ill_cnt  <= '0;
    end
    else
    begin
      if (done)
        done_cnt <= done_cnt + 1'b1;
      if (illegal)
        ill_cnt <= ill_cnt + 1'b1;
    end
  end

  always_comb
  begin
    case (csr_addr)
      `ALU_CSR_MASK:     csr_rdata = op_mask;
      `ALU_CSR_DONE_CNT: csr_rdata = done_cnt;
      `ALU_CSR_ILL_CNT:  csr_rdata = ill_cnt;
      default:           csr_rdata = '0;        // Address 3 unused
    endcase
  end

endmodule

/* verilog/op_queue.sv */
// Operation queue: in-order circular buffer for credited pushes
`timescale 1ns/1ps

`include "alu_defines.svh"

module op_queue (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  alu_pkg::alu_op_t push_op,
  input  alu_pkg::word_t   push_a,
  input  alu_pkg::word_t   push_b,
  input  logic             pop,
  output logic             head_valid,
  output alu_pkg::alu_op_t head_op,
  output alu_pkg::word_t   head_a,
  output alu_pkg::word_t   head_b
);
  import alu_pkg::*;

  localparam int DEPTH = `ALU_QUEUE_DEPTH;
  localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);

  alu_op_t        op_mem [DEPTH]; // Payload storage
  word_t          a_mem  [DEPTH];
  word_t          b_mem  [DEPTH];
  logic [PW-1:0]  wr_ptr;
  logic [PW-1:0]  rd_ptr;
  logic [CW-1:0]  count;          // Occupancy, credits keep it <= DEPTH

  assign head_valid = (count != '0);
  assign head_op    = op_mem[rd_ptr];
  assign head_a     = a_mem[rd_ptr];
  assign head_b     = b_mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      op_mem[wr_ptr] <= push_op;
      a_mem[wr_ptr]  <= push_a;
      b_mem[wr_ptr]  <= push_b;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
      if (pop)
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CW'(push) - CW'(pop); // Both at once keeps count
    end
  end

endmodule

/* verilog/alu.sv */
// Combinational ALU with zero, negative and borrow flags
`timescale 1ns/1ps

`include "alu_defines.svh"

module alu (
  input  alu_pkg::alu_op_t op,
  input  alu_pkg::word_t   a,
  input  alu_pkg::word_t   b,
  output alu_pkg::word_t   result,
  output logic             zero,
  output logic             negative,
  output logic             borrow
);
  import alu_pkg::*;

  logic signed [`ALU_XLEN-1:0] s_a; // Signed views for compares and sra
  logic signed [`ALU_XLEN-1:0] s_b;

  assign s_a = a;
  assign s_b = b;

  assign zero     = (result == '0);           // Flags follow the result
  assign negative = result[`ALU_XLEN-1];

  always_comb
  begin
    result = '0;                              // Unknown codes give zero
    borrow = 1'b0;                            // Only the borrow sub sets it
    case (op)
      OP_AND:     result = a & b;
      OP_OR:      result = a | b;
      OP_ADD:     result = a + b;
      OP_XOR:     result = a ^ b;
      OP_SUB:     result = a - b;
      OP_NOT:     result = ~a;               // b ignored
      OP_SLL:     result = a << b;           // Full b, large amounts flush
      OP_SRL:     result = a >> b;
      OP_SRA:     result = s_a >>> b;        // Sign fill
      OP_SLT:     result = word_t'(s_a < s_b);
      OP_SLTU:    result = word_t'(a < b);
      OP_AMOMIN:  result = (s_a < s_b) ? a : b;
      OP_AMOMAX:  result = (s_a > s_b) ? a : b;
      OP_AMOMINU: result = (a < b) ? a : b;
      OP_AMOMAXU: result = (a > b) ? a : b;
      OP_SUB_BORROW:
      begin
        // Extra top bit catches the borrow when b exceeds a
        {borrow, result} = {1'b0, a} - {1'b0, b};
      end
      default:    result = '0;               // mul/div/rem and 24..31
    endcase
  end

endmodule

/* verilog/alu_pkg.sv */
// ALU package: operand, opcode, mask and counter types plus opcode codes
package alu_pkg;

  `include "alu_defines.svh"

  typedef logic [`ALU_XLEN-1:0] word_t;    // Operand or result
  typedef logic [4:0]           alu_op_t;  // Opcode
  typedef logic [31:0]          op_mask_t; // One enable bit per opcode
  typedef logic [31:0]          cnt_t;     // Event counter

  localparam alu_op_t OP_AND        = 5'd0;
  localparam alu_op_t OP_OR         = 5'd1;
  localparam alu_op_t OP_ADD        = 5'd2;
  localparam alu_op_t OP_XOR        = 5'd3;
  localparam alu_op_t OP_SUB        = 5'd4;
  localparam alu_op_t OP_NOT        = 5'd5;
  localparam alu_op_t OP_SLL        = 5'd6;
  localparam alu_op_t OP_SRL        = 5'd7;
  localparam alu_op_t OP_SRA        = 5'd8;
  localparam alu_op_t OP_SLT        = 5'd9;
  localparam alu_op_t OP_SLTU       = 5'd10;
  localparam alu_op_t OP_MUL        = 5'd11; // Not implemented
  localparam alu_op_t OP_MULH       = 5'd12; // Not implemented
  localparam alu_op_t OP_MULHSU     = 5'd13; // Not implemented
  localparam alu_op_t OP_MULHU      = 5'd14; // Not implemented
  localparam alu_op_t OP_DIV        = 5'd15; // Not implemented
  localparam alu_op_t OP_DIVU       = 5'd16; // Not implemented
  localparam alu_op_t OP_REM        = 5'd17; // Not implemented
  localparam alu_op_t OP_REMU       = 5'd18; // Not implemented
  localparam alu_op_t OP_AMOMIN     = 5'd19;
  localparam alu_op_t OP_AMOMAX     = 5'd20;
  localparam alu_op_t OP_AMOMINU    = 5'd21;
  localparam alu_op_t OP_AMOMAXU    = 5'd22;
  localparam alu_op_t OP_SUB_BORROW = 5'd23; // Unsigned sub, borrow out

endpackage

/* verilog/alu_defines.svh */
// ALU execute unit defines: widths, queue and credit sizes, register map
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

`define ALU_XLEN         32            // Operand and result width
`define ALU_QUEUE_DEPTH  4             // Queue entries, also initial input credits
`define ALU_OUT_CREDITS  2             // Output credits held after reset

`define ALU_CSR_MASK     2'd0          // Opcode enable mask
`define ALU_CSR_DONE_CNT 2'd1          // Completed ops, read only
`define ALU_CSR_ILL_CNT  2'd2          // Illegal ops, read only

// Opcodes 0..10 and 19..23, mul/div/rem and 24..31 left out
`define ALU_OP_IMPL      32'h00F8_07FF

`endif
